//--- Bender.yml
package:
  name: afifo

sources:
  # Package first, then leaf modules, then the top level
  - source/afifo_pkg.sv
  - source/gray_ptr_sync.sv
  - source/afifo_wr_ctrl.sv
  - source/afifo_rd_ctrl.sv
  - source/afifo_dpram.sv
  - source/afifo_top.sv

  # Testbench and its included table
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/afifo_tb.sv

//--- compile.f
+incdir+sim
source/afifo_pkg.sv
source/gray_ptr_sync.sv
source/afifo_wr_ctrl.sv
source/afifo_rd_ctrl.sv
source/afifo_dpram.sv
source/afifo_top.sv
sim/afifo_tb.sv

//--- sim/afifo_tb_table.svh
// Phase table for the FIFO testbench with expected flags once quiet

// Number of phases applied by the main loop
localparam int NUM_PHASES = 14;

phase_t phases [NUM_PHASES];

// ----------------------------------------------------------
// Columns: pushes, pops, run together, push while full,
// {full, almost_full}, {empty, almost_empty}
// ----------------------------------------------------------
// Expected flags follow from n words held after the phase
// almost_full when DEPTH - n <= 2, almost_empty when n <= 2
task automatic load_phases();
    // Straight out of reset, n = 0
    phases[0]  = '{0,   0,   1'b0, 1'b0, 2'b00, 2'b11};
    // Climb one word at a time through the low threshold
    phases[1]  = '{1,   0,   1'b0, 1'b0, 2'b00, 2'b01};
    phases[2]  = '{1,   0,   1'b0, 1'b0, 2'b00, 2'b01};
    phases[3]  = '{1,   0,   1'b0, 1'b0, 2'b00, 2'b00};
    // n = 13, three free entries
    phases[4]  = '{10,  0,   1'b0, 1'b0, 2'b00, 2'b00};
    // Through the high threshold
    phases[5]  = '{1,   0,   1'b0, 1'b0, 2'b01, 2'b00};
    phases[6]  = '{1,   0,   1'b0, 1'b0, 2'b01, 2'b00};
    // Fill the last entry, then try one push too many
    phases[7]  = '{1,   0,   1'b0, 1'b1, 2'b11, 2'b00};
    // Drain all DEPTH words
    phases[8]  = '{0,   16,  1'b0, 1'b0, 2'b00, 2'b11};
    // Pointers now sit mid array, n = 2
    phases[9]  = '{5,   3,   1'b0, 1'b0, 2'b00, 2'b01};
    phases[10] = '{0,   2,   1'b0, 1'b0, 2'b00, 2'b11};
    // Random traffic on both sides, wraps pointers many times
    phases[11] = '{240, 240, 1'b1, 1'b0, 2'b00, 2'b11};
    // Random traffic that leaves n = 14 behind
    phases[12] = '{64,  50,  1'b1, 1'b0, 2'b01, 2'b00};
    phases[13] = '{0,   14,  1'b0, 1'b0, 2'b00, 2'b11};
endtask

//--- sim/afifo_tb.sv
// Testbench for the dual-clock FIFO with clocks, reset, scoreboard, compare tasks, phase loop
module afifo_tb
    import afifo_pkg::*;
();

    // ----------------------------------------------------------
    // Constants and types
    // ----------------------------------------------------------
    localparam int WAIT_LIMIT = 500;
    // Quiet time in rd_clk cycles, covers both crossings
    localparam int SETTLE_EDGES = 2 * (SYNC_STAGES + 2);

    // Flags held while reset is low
    localparam wr_stat_t WR_STAT_RESET = '{full: 1'b0, almost_full: 1'b0};
    localparam rd_stat_t RD_STAT_RESET = '{empty: 1'b1, almost_empty: 1'b1};

    // One row of the stimulus table
    typedef struct packed {
        int       pushes;
        int       pops;
        logic     concurrent;
        logic     over_push;
        wr_stat_t exp_wr;
        rd_stat_t exp_rd;
    } phase_t;

    logic     wr_clk;
    logic     rd_clk;
    logic     rd_rst_n;
    wr_req_t  wr_req;
    wr_stat_t wr_stat;
    logic     pop;
    data_t    rd_data;
    rd_stat_t rd_stat;

    // Every accepted word in push order
    data_t    scoreboard [$];
    // Running value for the next pushed word
    data_t    next_word;

    `include "afifo_tb_table.svh"

    // ----------------------------------------------------------
    // Clocks and DUT
    // ----------------------------------------------------------
    initial begin
        wr_clk = 1'b0;
        forever #10 wr_clk = ~wr_clk;
    end

    initial begin
        rd_clk = 1'b0;
        forever #17 rd_clk = ~rd_clk;
    end

    afifo_top i_afifo_top (
        .i_wr_clk  (wr_clk),
        .i_rd_clk  (rd_clk),
        .i_rst_n   (rd_rst_n),
        .i_wr_req  (wr_req),
        .o_wr_stat (wr_stat),
        .i_pop     (pop),
        .o_rd_data (rd_data),
        .o_rd_stat (rd_stat)
    );

    // ----------------------------------------------------------
    // Failure handling and compare tasks
    // ----------------------------------------------------------
    task automatic stop_run();
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_data(input data_t got, input data_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t: read data %h, expected %h", $time, got, exp);
            stop_run();
        end
    endtask

    task automatic check_wr_stat(input wr_stat_t got, input wr_stat_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t: full %b almost_full %b, expected %b %b",
                     $time, got.full, got.almost_full, exp.full, exp.almost_full);
            stop_run();
        end
    endtask

    task automatic check_rd_stat(input rd_stat_t got, input rd_stat_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t: empty %b almost_empty %b, expected %b %b",
                     $time, got.empty, got.almost_empty, exp.empty, exp.almost_empty);
            stop_run();
        end
    endtask

    // ----------------------------------------------------------
    // Write and read drivers
    // ----------------------------------------------------------
    // Flags sampled at negedge, request driven at posedge
    // A push seen with full low at negedge lands on the next posedge
    task automatic push_words(input int count, input bit gaps);
        int   accepted;
        int   idle;
        logic try_push;
        logic full_seen;
        accepted = 0;
        idle = 0;
        @(negedge wr_clk);
        full_seen = wr_stat.full;
        while (accepted < count) begin
            @(posedge wr_clk);
            try_push = !full_seen && (!gaps || ($urandom_range(3) != 0));
            wr_req <= '{push: try_push, data: next_word};
            @(negedge wr_clk);
            full_seen = wr_stat.full;
            if (try_push && !full_seen) begin
                scoreboard.push_back(next_word);
                next_word = next_word + 1'b1;
                accepted++;
                idle = 0;
            end else begin
                idle++;
                if (idle > WAIT_LIMIT) begin
                    $display("Timeout at %0t: write side never left full", $time);
                    stop_run();
                end
            end
        end
        // Last word is taken at this edge
        @(posedge wr_clk);
        wr_req <= '{push: 1'b0, data: '0};
    endtask

    // Head word is compared before the edge that consumes it
    task automatic pop_words(input int count, input bit gaps);
        int    taken;
        int    idle;
        logic  try_pop;
        logic  empty_seen;
        data_t expected;
        taken = 0;
        idle = 0;
        @(negedge rd_clk);
        empty_seen = rd_stat.empty;
        while (taken < count) begin
            @(posedge rd_clk);
            try_pop = !empty_seen && (!gaps || ($urandom_range(3) != 0));
            pop <= try_pop;
            @(negedge rd_clk);
            empty_seen = rd_stat.empty;
            if (try_pop && !empty_seen) begin
                if (scoreboard.size() == 0) begin
                    $display("Read side offered a word that was never pushed at %0t", $time);
                    stop_run();
                end
                expected = scoreboard.pop_front();
                check_data(rd_data, expected);
                taken++;
                idle = 0;
            end else begin
                idle++;
                if (idle > WAIT_LIMIT) begin
                    $display("Timeout at %0t: read side never left empty", $time);
                    stop_run();
                end
            end
        end
        @(posedge rd_clk);
        pop <= 1'b0;
    endtask

    // One push while full, must not be stored
    task automatic push_while_full();
        int idle;
        idle = 0;
        @(negedge wr_clk);
        while (!wr_stat.full) begin
            idle++;
            if (idle > WAIT_LIMIT) begin
                $display("Timeout at %0t: full never asserted", $time);
                stop_run();
            end
            @(negedge wr_clk);
        end
        @(posedge wr_clk);
        wr_req <= '{push: 1'b1, data: 16'hbad0};
        @(posedge wr_clk);
        wr_req <= '{push: 1'b0, data: '0};
    endtask

    // Bounded quiet time so both crossings catch up
    task automatic settle();
        for (int e = 0; e < SETTLE_EDGES; e++) begin
            @(negedge rd_clk);
        end
    endtask

    // ----------------------------------------------------------
    // One table row
    // ----------------------------------------------------------
    task automatic run_phase(input phase_t ph);
        if (ph.concurrent) begin
            fork
                push_words(ph.pushes, 1'b1);
                pop_words(ph.pops, 1'b1);
            join
        end else begin
            push_words(ph.pushes, 1'b0);
            pop_words(ph.pops, 1'b0);
        end
        if (ph.over_push) begin
            push_while_full();
        end
        settle();
        @(negedge wr_clk);
        check_wr_stat(wr_stat, ph.exp_wr);
        @(negedge rd_clk);
        check_rd_stat(rd_stat, ph.exp_rd);
        // Empty FIFO means nothing left to read
        if (rd_stat.empty && scoreboard.size() != 0) begin
            $display("FIFO reports empty with %0d words still expected at %0t",
                     scoreboard.size(), $time);
            stop_run();
        end
    endtask

    // ----------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------
    initial begin
        void'($urandom(32'h388a_43a7));
        rd_rst_n  = 1'b0;
        wr_req    = '0;
        pop       = 1'b0;
        next_word = '0;
        load_phases();
        repeat (9) @(posedge wr_clk);
        // Both domains have seen several reset edges by now
        @(negedge wr_clk);
        check_wr_stat(wr_stat, WR_STAT_RESET);
        check_rd_stat(rd_stat, RD_STAT_RESET);
        @(posedge wr_clk);
        rd_rst_n <= 1'b1;
        for (int p = 0; p < NUM_PHASES; p++) begin
            run_phase(phases[p]);
        end
        $display("TEST PASSED");
        $finish;
    end

endmodule : afifo_tb

//--- source/afifo_dpram.sv
// Storage array with a wr_clk write port and a combinational read port
module afifo_dpram
    import afifo_pkg::*;
(
    input  logic  i_wr_clk,
    // Write port, enable already qualified by not full
    input  logic  i_we,
    input  addr_t i_waddr,
    input  data_t i_wdata,
    // Read port, no clock
    input  addr_t i_raddr,
    output data_t o_rdata
);

    // ----------------------------------------------------------
    // Storage
    // ----------------------------------------------------------
    // DEPTH words, written from wr_clk and read by address
    data_t mem [DEPTH];

    // ----------------------------------------------------------
    // Write port
    // ----------------------------------------------------------
    always_ff @(posedge i_wr_clk) begin
        if (i_we) begin
            mem[i_waddr] <= i_wdata;
        end
    end

    // ----------------------------------------------------------
    // Read port
    // ----------------------------------------------------------
    // Head word straight out of the array
    // Address is stable in rd_clk, data may change when a new
    // word lands at an address the read side already points at
    assign o_rdata = mem[i_raddr];

endmodule : afifo_dpram

//--- source/afifo_pkg.sv
// Sizes, flag margins and packed struct types for the dual-clock FIFO
package afifo_pkg;

    // ----------------------------------------------------------
    // Sizes
    // ----------------------------------------------------------

    // Width of one data word
    localparam int DATA_W = 16;

    // Number of entries, kept a power of two so the wrap bit works
    localparam int DEPTH = 16;

    // Storage address width
    localparam int ADDR_W = 4;

    // Address plus one wrap bit
    // Wrap bit tells full from empty when addresses match
    localparam int PTR_W = ADDR_W + 1;

    // Flops per pointer crossing
    localparam int SYNC_STAGES = 2;

    // ----------------------------------------------------------
    // Flag margins
    // ----------------------------------------------------------

    // Almost-full when free entries drop to this or below
    localparam int ALMOST_WR_MARGIN = 2;

    // Almost-empty when held entries drop to this or below
    localparam int ALMOST_RD_MARGIN = 2;

    // ----------------------------------------------------------
    // Types
    // ----------------------------------------------------------

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [ADDR_W-1:0] addr_t;

    // Same type for binary and Gray forms of a pointer
    typedef logic [PTR_W-1:0] ptr_t;

    // Write side request, push qualifies data
    typedef struct packed {
        logic  push;
        data_t data;
    } wr_req_t;

    // Write side status, both registered in wr_clk domain
    typedef struct packed {
        logic full;
        logic almost_full;
    } wr_stat_t;

    // Read side status, both registered in rd_clk domain
    typedef struct packed {
        logic empty;
        logic almost_empty;
    } rd_stat_t;

endpackage : afifo_pkg

//--- source/afifo_rd_ctrl.sv
// Read pointer counter, read qualification, empty and almost-empty flags
module afifo_rd_ctrl
    import afifo_pkg::*;
(
    input  logic     i_rd_clk,
    input  logic     i_rst_n,
    // User pop, consumes the head word
    input  logic     i_pop,
    // Write pointer in Gray form, still in wr_clk domain
    input  ptr_t     i_wr_gray,
    // Registered Gray read pointer for the write side
    output ptr_t     o_rd_gray,
    // Storage read address
    output addr_t    o_mem_raddr,
    output rd_stat_t o_rd_stat
);

    ptr_t     rd_bin_q;
    ptr_t     rd_gray_q;
    ptr_t     rd_bin_next;
    ptr_t     rd_gray_next;
    ptr_t     wr_bin_sync;
    ptr_t     held_next;
    logic     pop_ok;
    rd_stat_t stat_q;
    rd_stat_t stat_next;

    // ----------------------------------------------------------
    // Write pointer crossing into rd_clk
    // ----------------------------------------------------------
    gray_ptr_sync i_wr_ptr_sync (
        .i_clk   (i_rd_clk),
        .i_rst_n (i_rst_n),
        .i_gray  (i_wr_gray),
        .o_bin   (wr_bin_sync)
    );

    // ----------------------------------------------------------
    // Next pointer and flags
    // ----------------------------------------------------------
    // Pop while empty leaves the pointer alone
    assign pop_ok = i_pop & ~stat_q.empty;

    assign rd_bin_next  = rd_bin_q + ptr_t'(pop_ok);
    assign rd_gray_next = (rd_bin_next >> 1) ^ rd_bin_next;

    // Entries still held after this edge
    assign held_next = wr_bin_sync - rd_bin_next;

    // Empty: pointers equal including wrap bit
    assign stat_next.empty = (rd_bin_next == wr_bin_sync);

    // Held entries at or below margin
    assign stat_next.almost_empty = (held_next <= ptr_t'(ALMOST_RD_MARGIN));

    // ----------------------------------------------------------
    // Pointer and flag registers
    // ----------------------------------------------------------
    always_ff @(posedge i_rd_clk) begin
        if (!i_rst_n) begin
            rd_bin_q  <= '0;
            rd_gray_q <= '0;
            // Nothing held out of reset
            stat_q    <= '{empty: 1'b1, almost_empty: 1'b1};
        end else begin
            rd_bin_q  <= rd_bin_next;
            rd_gray_q <= rd_gray_next;
            stat_q    <= stat_next;
        end
    end

    // Head address follows the registered pointer
    // so the next word shows up right after a pop edge
    assign o_mem_raddr = rd_bin_q[ADDR_W-1:0];

    assign o_rd_gray = rd_gray_q;
    assign o_rd_stat = stat_q;

endmodule : afifo_rd_ctrl

//--- source/afifo_top.sv
// Top level joining the write controller, read controller and storage
module afifo_top
    import afifo_pkg::*;
(
    input  logic     i_wr_clk,
    input  logic     i_rd_clk,
    // Shared synchronous reset, sampled on each clock
    input  logic     i_rst_n,

    // wr_clk domain
    input  wr_req_t  i_wr_req,
    output wr_stat_t o_wr_stat,

    // rd_clk domain
    input  logic     i_pop,
    output data_t    o_rd_data,
    output rd_stat_t o_rd_stat
);

    // Gray pointers crossing between domains
    ptr_t  wr_gray;
    ptr_t  rd_gray;

    // Storage connections
    logic  mem_we;
    addr_t mem_waddr;
    data_t mem_wdata;
    addr_t mem_raddr;

    // ----------------------------------------------------------
    // Write side
    // ----------------------------------------------------------
    afifo_wr_ctrl i_afifo_wr_ctrl (
        .i_wr_clk    (i_wr_clk),
        .i_rst_n     (i_rst_n),
        .i_wr_req    (i_wr_req),
        .i_rd_gray   (rd_gray),
        .o_wr_gray   (wr_gray),
        .o_mem_we    (mem_we),
        .o_mem_waddr (mem_waddr),
        .o_mem_wdata (mem_wdata),
        .o_wr_stat   (o_wr_stat)
    );

    // ----------------------------------------------------------
    // Read side
    // ----------------------------------------------------------
    afifo_rd_ctrl i_afifo_rd_ctrl (
        .i_rd_clk    (i_rd_clk),
        .i_rst_n     (i_rst_n),
        .i_pop       (i_pop),
        .i_wr_gray   (wr_gray),
        .o_rd_gray   (rd_gray),
        .o_mem_raddr (mem_raddr),
        .o_rd_stat   (o_rd_stat)
    );

    // ----------------------------------------------------------
    // Storage
    // ----------------------------------------------------------
    // Written from wr_clk, read by address from rd_clk side
    afifo_dpram i_afifo_dpram (
        .i_wr_clk (i_wr_clk),
        .i_we     (mem_we),
        .i_waddr  (mem_waddr),
        .i_wdata  (mem_wdata),
        .i_raddr  (mem_raddr),
        .o_rdata  (o_rd_data)
    );

endmodule : afifo_top

//--- source/afifo_wr_ctrl.sv
// Write pointer counter, write qualification, full and almost-full flags
module afifo_wr_ctrl
    import afifo_pkg::*;
(
    input  logic     i_wr_clk,
    input  logic     i_rst_n,
    // User write request
    input  wr_req_t  i_wr_req,
    // Read pointer in Gray form, still in rd_clk domain
    input  ptr_t     i_rd_gray,
    // Registered Gray write pointer for the read side
    output ptr_t     o_wr_gray,
    // Storage write port
    output logic     o_mem_we,
    output addr_t    o_mem_waddr,
    output data_t    o_mem_wdata,
    output wr_stat_t o_wr_stat
);

    ptr_t     wr_bin_q;
    ptr_t     wr_gray_q;
    ptr_t     wr_bin_next;
    ptr_t     wr_gray_next;
    ptr_t     rd_bin_sync;
    ptr_t     used_next;
    logic     push_ok;
    wr_stat_t stat_q;
    wr_stat_t stat_next;

    // ----------------------------------------------------------
    // Read pointer crossing into wr_clk
    // ----------------------------------------------------------
    gray_ptr_sync i_rd_ptr_sync (
        .i_clk   (i_wr_clk),
        .i_rst_n (i_rst_n),
        .i_gray  (i_rd_gray),
        .o_bin   (rd_bin_sync)
    );

    // ----------------------------------------------------------
    // Next pointer and flags
    // ----------------------------------------------------------
    // Push while full is dropped here and never reaches storage
    assign push_ok = i_wr_req.push & ~stat_q.full;

    assign wr_bin_next  = wr_bin_q + ptr_t'(push_ok);
    assign wr_gray_next = (wr_bin_next >> 1) ^ wr_bin_next;

    // Entries held as seen from this side, 0 to DEPTH
    assign used_next = wr_bin_next - rd_bin_sync;

    // Full: same address, opposite wrap bit
    assign stat_next.full = (wr_bin_next[ADDR_W-1:0] == rd_bin_sync[ADDR_W-1:0]) &&
                            (wr_bin_next[PTR_W-1] != rd_bin_sync[PTR_W-1]);

    // Free entries at or below margin
    assign stat_next.almost_full = (used_next >= ptr_t'(DEPTH - ALMOST_WR_MARGIN));

    // ----------------------------------------------------------
    // Pointer and flag registers
    // ----------------------------------------------------------
    always_ff @(posedge i_wr_clk) begin
        if (!i_rst_n) begin
            wr_bin_q  <= '0;
            wr_gray_q <= '0;
            stat_q    <= '0;
        end else begin
            wr_bin_q  <= wr_bin_next;
            wr_gray_q <= wr_gray_next;
            stat_q    <= stat_next;
        end
    end

    // Storage write uses the current pointer, so data lands this edge
    assign o_mem_we    = push_ok;
    assign o_mem_waddr = wr_bin_q[ADDR_W-1:0];
    assign o_mem_wdata = i_wr_req.data;

    assign o_wr_gray = wr_gray_q;
    assign o_wr_stat = stat_q;

endmodule : afifo_wr_ctrl

//--- source/gray_ptr_sync.sv
// Synchronizer chain for a Gray pointer with Gray-to-binary conversion
module gray_ptr_sync
    import afifo_pkg::*;
(
    input  logic i_clk,
    input  logic i_rst_n,
    // Gray pointer from the other clock domain
    input  ptr_t i_gray,
    // Binary pointer in the i_clk domain
    output ptr_t o_bin
);

    // Stage 0 is the capture flop, the last stage feeds the decoder
    ptr_t sync_q [SYNC_STAGES];
    ptr_t bin_c;

    // ----------------------------------------------------------
    // Synchronizer chain
    // ----------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            for (int s = 0; s < SYNC_STAGES; s++) begin
                sync_q[s] <= '0;
            end
        end else begin
            sync_q[0] <= i_gray;
            for (int s = 1; s < SYNC_STAGES; s++) begin
                sync_q[s] <= sync_q[s-1];
            end
        end
    end

    // ----------------------------------------------------------
    // Gray to binary
    // ----------------------------------------------------------
    // Top bit passes straight, each lower bit folds in the one above
    always_comb begin
        bin_c[PTR_W-1] = sync_q[SYNC_STAGES-1][PTR_W-1];
        for (int i = PTR_W - 2; i >= 0; i--) begin
            bin_c[i] = bin_c[i+1] ^ sync_q[SYNC_STAGES-1][i];
        end
    end

    assign o_bin = bin_c;

endmodule : gray_ptr_sync
